/* source/usb_rx_pkg.sv */
`default_nettype none

package usb_rx_pkg;

    // line condition as {dp, dm}
    typedef enum logic [1:0] {
        SE0 = 2'b00,
        K   = 2'b01,
        J   = 2'b10,
        SE1 = 2'b11
    } line_state_t;

    // one received byte, last marks the end of the packet
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } rx_byte_t;

    typedef struct packed {
        logic receiving;  // packet in progress
        logic data_ready; // fifo holds data
        logic rx_error;   // sticky until next packet
    } rx_status_t;

    // KJKJKJKK after nrzi decoding, lsb first
    localparam logic [7:0] SYNC_BYTE = 8'h80;

endpackage

`default_nettype wire

/* source/flex_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module flex_counter #(
    parameter int NUM_CNT_BITS = 4
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     clear,
    input  wire                     count_enable,
    input  wire  [NUM_CNT_BITS-1:0] rollover_val,
    output logic [NUM_CNT_BITS-1:0] count_out,
    output logic                    rollover_flag
);

    logic [NUM_CNT_BITS-1:0] next_count;

    always_comb begin
        next_count = count_out;
        if (clear) begin
            next_count = '0;
        end else if (count_enable) begin
            if (count_out == rollover_val) begin
                next_count = NUM_CNT_BITS'(1); // wrap back to 1
            end else begin
                next_count = count_out + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_out     <= '0;
            rollover_flag <= 1'b0;
        end else begin
            count_out     <= next_count;
            rollover_flag <= (next_count == rollover_val);
        end
    end

    a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count_out <= rollover_val);

endmodule

`default_nettype wire

/* source/bit_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_timer #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  stuff_bit,
    input  wire  enable,
    input  wire  clear,
    output logic shift,
    output logic one_byte_time
);

    localparam int CLK_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CLK_W-1:0] CLK_ROLL = CLK_W'(CLKS_PER_BIT);
    localparam logic [CLK_W-1:0] SHIFT_AT = CLK_W'(CLKS_PER_BIT / 2); // mid-bit

    typedef enum logic {IDLE, CANCEL} cancel_state_t;

    cancel_state_t state, next_state;
    logic [CLK_W-1:0] clk_count;
    logic             clk_roll;
    logic [3:0]       bit_count;
    logic             cancel;
    logic             bit_en;

    flex_counter #(.NUM_CNT_BITS(CLK_W)) i_clk_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .count_enable (enable),
        .rollover_val (CLK_ROLL),
        .count_out    (clk_count),
        .rollover_flag(clk_roll)
    );

    assign shift = enable && (clk_count == SHIFT_AT);

    // stuffed bit is dropped from the byte count
    assign cancel = stuff_bit || (state == CANCEL);
    assign bit_en = shift && !cancel;

    flex_counter #(.NUM_CNT_BITS(4)) i_bit_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .count_enable (bit_en),
        .rollover_val (4'd8),
        .count_out    (bit_count),
        .rollover_flag()
    );

    assign one_byte_time = bit_en && (bit_count == 4'd7); // eighth data bit

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (stuff_bit) next_state = CANCEL;
            CANCEL:  if (clk_roll) next_state = IDLE; // end of the stuffed bit
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (clear) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    a_stuff_on_shift: assert property (@(posedge clk) disable iff (!rst_n)
        stuff_bit |-> shift);

endmodule

`default_nettype wire

/* source/line_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module line_decoder #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dp,
    input  wire                     dm,
    input  wire                     shift,
    output usb_rx_pkg::line_state_t line,
    output logic                    d_orig,
    output logic                    edge_seen,
    output logic                    stuff_bit,
    output logic                    eop
);

    localparam int SE0_W = $clog2(CLKS_PER_BIT + 1);

    logic                    dp_meta, dp_sync;
    logic                    dm_meta, dm_sync;
    usb_rx_pkg::line_state_t line_q;    // line one clock ago
    usb_rx_pkg::line_state_t bit_line;  // line at the last sample point
    logic [2:0]              ones;
    logic [SE0_W-1:0]        se0_cnt;
    logic                    data_line;
    logic                    sample;

    // synchronizers reset to idle J
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_meta <= 1'b1;
            dp_sync <= 1'b1;
            dm_meta <= 1'b0;
            dm_sync <= 1'b0;
        end else begin
            dp_meta <= dp;
            dp_sync <= dp_meta;
            dm_meta <= dm;
            dm_sync <= dm_meta;
        end
    end

    assign line      = usb_rx_pkg::line_state_t'({dp_sync, dm_sync});
    assign edge_seen = (line != line_q);

    assign data_line = (line == usb_rx_pkg::J) || (line == usb_rx_pkg::K);
    assign sample    = shift && data_line;

    // nrzi: no change means 1
    assign d_orig    = (line == bit_line);
    assign stuff_bit = sample && (ones == 3'd6) && !d_orig;

    assign eop = (line == usb_rx_pkg::SE0) && (se0_cnt == SE0_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_q   <= usb_rx_pkg::J;
            bit_line <= usb_rx_pkg::J;
            ones     <= 3'd0;
        end else begin
            line_q <= line;
            if (eop) begin
                bit_line <= usb_rx_pkg::J; // next packet starts from idle
                ones     <= 3'd0;
            end else if (sample) begin
                bit_line <= line;
                if (!d_orig) begin
                    ones <= 3'd0;
                end else if (ones != 3'd7) begin
                    ones <= ones + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            se0_cnt <= '0;
        end else if (line != usb_rx_pkg::SE0) begin
            se0_cnt <= '0;
        end else if (se0_cnt != SE0_W'(CLKS_PER_BIT)) begin
            se0_cnt <= se0_cnt + 1'b1; // saturates, one eop per SE0
        end
    end

endmodule

`default_nettype wire

/* source/rx_control.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_control (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire usb_rx_pkg::line_state_t line,
    input  wire                     edge_seen,
    input  wire                     d_orig,
    input  wire                     stuff_bit,
    input  wire                     eop,
    input  wire                     shift,
    input  wire                     one_byte_time,
    input  wire                     full,
    input  wire                     empty,
    output logic                    timer_enable,
    output logic                    timer_clear,
    output logic                    w_enable,
    output usb_rx_pkg::rx_byte_t    w_data,
    output usb_rx_pkg::rx_status_t  status
);

    typedef enum logic [2:0] {IDLE, SYNC, DATA, EOP_WAIT, ERROR_WAIT} state_t;

    state_t     state, next_state;
    logic [7:0] sr;
    logic [2:0] bit_cnt;     // bits into the current byte
    logic [7:0] pend_data;
    logic       pend_valid;
    logic       error_flag;
    logic       data_line;
    logic       bit_valid;
    logic       byte_done;
    logic [7:0] new_byte;
    logic       start;
    logic       bad_sync;
    logic       partial_eop;
    logic       push_req;
    logic       overflow;

    // SE0 samples before eop are not data
    assign data_line = (line == usb_rx_pkg::J) || (line == usb_rx_pkg::K);
    assign bit_valid = shift && !stuff_bit && data_line;
    assign byte_done = one_byte_time && data_line;
    assign new_byte  = {d_orig, sr[7:1]}; // lsb first

    assign start       = (state == IDLE) && edge_seen && (line == usb_rx_pkg::K);
    assign bad_sync    = (state == SYNC) && byte_done && (new_byte != usb_rx_pkg::SYNC_BYTE);
    assign partial_eop = eop && ((state == SYNC) || ((state == DATA) && (bit_cnt != 3'd0)));
    assign push_req    = (state == DATA) && pend_valid && (byte_done || eop);
    assign overflow    = push_req && full;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (start) next_state = SYNC;
            SYNC: begin
                if (eop) begin
                    next_state = EOP_WAIT;
                end else if (byte_done) begin
                    next_state = bad_sync ? ERROR_WAIT : DATA;
                end
            end
            DATA: begin
                if (eop) begin
                    next_state = EOP_WAIT;
                end else if (overflow) begin
                    next_state = ERROR_WAIT;
                end
            end
            ERROR_WAIT: if (eop) next_state = EOP_WAIT;
            EOP_WAIT:   if (line == usb_rx_pkg::J) next_state = IDLE; // back to idle
            default:    next_state = IDLE;
        endcase
    end

    assign timer_enable = (state == SYNC) || (state == DATA);
    assign timer_clear  = timer_enable && (next_state != SYNC) && (next_state != DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            bit_cnt    <= 3'd0;
            pend_valid <= 1'b0;
            error_flag <= 1'b0;
            w_enable   <= 1'b0;
        end else begin
            state    <= next_state;
            w_enable <= push_req && !full; // dropped when full
            if (start) begin
                bit_cnt    <= 3'd0;
                pend_valid <= 1'b0;
                error_flag <= 1'b0;
            end else begin
                if (bit_valid) bit_cnt <= bit_cnt + 3'd1;
                if (bad_sync || partial_eop || overflow) error_flag <= 1'b1;
                if ((state == DATA) && byte_done) pend_valid <= 1'b1;
                if (eop) pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_valid) sr <= new_byte;
        if ((state == DATA) && byte_done) pend_data <= new_byte;
        if (push_req) begin
            w_data.data <= pend_data;
            w_data.last <= eop; // held byte goes out last
        end
    end

    assign status = '{receiving: (state != IDLE), data_ready: !empty, rx_error: error_flag};

    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        w_enable |-> !full);

endmodule

`default_nettype wire

/* source/rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      w_enable,
    input  wire                      r_enable,
    input  wire usb_rx_pkg::rx_byte_t w_data,
    output usb_rx_pkg::rx_byte_t     r_data,
    output logic                     full,
    output logic                     empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    usb_rx_pkg::rx_byte_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr, rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_write, do_read;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_write = w_enable && !full;
    assign do_read  = r_enable && !empty;
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign r_data   = mem[rd_ptr]; // fall-through head

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= next_ptr(wr_ptr);
            if (do_read) rd_ptr <= next_ptr(rd_ptr);
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= w_data;
    end

    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        r_enable |-> !empty);

endmodule

`default_nettype wire

/* source/usb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx #(
    parameter int CLKS_PER_BIT = 8,
    parameter int FIFO_DEPTH   = 8
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    dp,
    input  wire                    dm,
    input  wire                    r_enable,
    output usb_rx_pkg::rx_byte_t   r_data,
    output logic                   empty,
    output logic                   full,
    output usb_rx_pkg::rx_status_t status
);

    usb_rx_pkg::line_state_t line;
    usb_rx_pkg::rx_byte_t    w_data;
    logic                    d_orig;
    logic                    edge_seen;
    logic                    stuff_bit;
    logic                    eop;
    logic                    shift;
    logic                    one_byte_time;
    logic                    timer_enable;
    logic                    timer_clear;
    logic                    w_enable;

    line_decoder #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_line_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .dp       (dp),
        .dm       (dm),
        .shift    (shift),
        .line     (line),
        .d_orig   (d_orig),
        .edge_seen(edge_seen),
        .stuff_bit(stuff_bit),
        .eop      (eop)
    );

    bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_bit_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .stuff_bit    (stuff_bit),
        .enable       (timer_enable),
        .clear        (timer_clear),
        .shift        (shift),
        .one_byte_time(one_byte_time)
    );

    rx_control i_rx_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .line         (line),
        .edge_seen    (edge_seen),
        .d_orig       (d_orig),
        .stuff_bit    (stuff_bit),
        .eop          (eop),
        .shift        (shift),
        .one_byte_time(one_byte_time),
        .full         (full),
        .empty        (empty),
        .timer_enable (timer_enable),
        .timer_clear  (timer_clear),
        .w_enable     (w_enable),
        .w_data       (w_data),
        .status       (status)
    );

    rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_enable(w_enable),
        .r_enable(r_enable),
        .w_data  (w_data),
        .r_data  (r_data),
        .full    (full),
        .empty   (empty)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

/* dv/tb_usb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_rx;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 8;
    localparam int NUM_PKTS     = 8;
    localparam int IDLE_BITS    = 4;

    typedef struct packed {
        logic [2:0]      n_bytes;
        logic [5:0][7:0] bytes;     // bytes[0] goes out first
        logic [7:0]      sync;
        logic            truncate;  // se0 after half a byte
        logic            hold;      // fifo left unread
        logic            exp_error;
    } pkt_t;

    logic                   clk;
    logic                   rst_n;
    logic                   dp;
    logic                   dm;
    logic                   r_enable;
    usb_rx_pkg::rx_byte_t   r_data;
    logic                   empty;
    logic                   full;
    usb_rx_pkg::rx_status_t status;

    pkt_t                 pkts [NUM_PKTS];
    usb_rx_pkg::rx_byte_t model [$];  // expected fifo contents
    integer               seed;
    int                   cycles = 0;
    int                   cycle_limit = 0;

    tb_clock #(.PERIOD_NS(10.0)) i_clock (.clk(clk));

    usb_rx #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .dp      (dp),
        .dm      (dm),
        .r_enable(r_enable),
        .r_data  (r_data),
        .empty   (empty),
        .full    (full),
        .status  (status)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    function automatic pkt_t make_pkt(input logic [2:0] n, input logic [47:0] data,
                                      input logic [7:0] sync, input logic truncate,
                                      input logic hold, input logic exp_error);
        pkt_t p;
        p.n_bytes   = n;
        p.bytes     = data;  // byte 0 in the low bits
        p.sync      = sync;
        p.truncate  = truncate;
        p.hold      = hold;
        p.exp_error = exp_error;
        return p;
    endfunction

    // worst case with a stuffed bit every six
    function automatic int pkt_cycles(input pkt_t p);
        int nbits;
        nbits = 8 * (int'(p.n_bytes) + 1) + 4;
        nbits = nbits + nbits / 6 + 1 + 2 + IDLE_BITS + 2;
        return nbits * CLKS_PER_BIT + 2 * FIFO_DEPTH + 4;
    endfunction

    task automatic drive_line(input logic [1:0] st, input int nbits);
        repeat (nbits * CLKS_PER_BIT) begin
            @(posedge clk);
            #1;
            {dp, dm} = st;
        end
    endtask

    // nrzi where a zero toggles the line
    task automatic drive_bit(input logic b, inout logic [1:0] level);
        if (!b) level = (level == usb_rx_pkg::J) ? usb_rx_pkg::K : usb_rx_pkg::J;
        drive_line(level, 1);
    endtask

    task automatic send_packet(input pkt_t p);
        logic       raw [$];
        logic [1:0] level;
        int         ones;
        for (int i = 0; i < 8; i++) raw.push_back(p.sync[i]);
        for (int k = 0; k < int'(p.n_bytes); k++) begin
            for (int i = 0; i < 8; i++) raw.push_back(p.bytes[k][i]);
        end
        if (p.truncate) begin
            for (int i = 0; i < 4; i++) raw.push_back(i[0]);
        end
        level = usb_rx_pkg::J;
        ones  = 0;
        foreach (raw[i]) begin
            drive_bit(raw[i], level);
            ones = raw[i] ? ones + 1 : 0;
            if (ones == 6) begin
                drive_bit(1'b0, level); // stuffed zero
                ones = 0;
            end
        end
        check("status.receiving", status.receiving, 1'b1);
        drive_line(usb_rx_pkg::SE0, 2);
        drive_line(usb_rx_pkg::J, 1);
        check("status.receiving", status.receiving, 1'b0); // idle once J is back
        drive_line(usb_rx_pkg::J, IDLE_BITS);
    endtask

    // bytes the fifo should keep until it fills
    task automatic model_packet(input pkt_t p);
        usb_rx_pkg::rx_byte_t b;
        if (p.sync == usb_rx_pkg::SYNC_BYTE) begin
            for (int k = 0; k < int'(p.n_bytes); k++) begin
                b.data = p.bytes[k];
                b.last = (k == int'(p.n_bytes) - 1);
                if (model.size() < FIFO_DEPTH) model.push_back(b);
            end
        end
    endtask

    task automatic drain_fifo();
        usb_rx_pkg::rx_byte_t exp;
        while (model.size() > 0) begin
            exp = model.pop_front();
            check("empty", empty, 1'b0);
            check("status.data_ready", status.data_ready, 1'b1);
            check("r_data.data", r_data.data, exp.data);
            check("r_data.last", r_data.last, exp.last);
            r_enable = 1'b1;
            @(posedge clk);
            #1;
            r_enable = 1'b0;
        end
        check("empty", empty, 1'b1);
        check("status.data_ready", status.data_ready, 1'b0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the packets were not all checked within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        rst_n    = 1'b0;
        dp       = 1'b1; // idle J
        dm       = 1'b0;
        r_enable = 1'b0;
        seed     = 38;

        pkts[0] = make_pkt(3, 48'h00_00_00_56_34_12, usb_rx_pkg::SYNC_BYTE, 0, 0, 0);
        pkts[1] = make_pkt(4, 48'h00_00_3f_7e_ff_ff, usb_rx_pkg::SYNC_BYTE, 0, 0, 0);
        pkts[2] = make_pkt(2, 48'h00_00_00_00_5a_a5, 8'h82, 0, 0, 1); // bad sync
        pkts[3] = make_pkt(2, 48'h00_00_00_00_3c_c3, usb_rx_pkg::SYNC_BYTE, 0, 0, 0);
        pkts[4] = make_pkt(2, 48'h00_00_00_00_22_11, usb_rx_pkg::SYNC_BYTE, 1, 0, 1);
        pkts[5] = make_pkt(6, 48'h06_05_04_03_02_01, usb_rx_pkg::SYNC_BYTE, 0, 1, 0);
        pkts[6] = make_pkt(6, 48'hf5_f4_f3_f2_f1_f0, usb_rx_pkg::SYNC_BYTE, 0, 0, 1);
        pkts[7] = make_pkt(6, 48'h0, usb_rx_pkg::SYNC_BYTE, 0, 0, 0);
        for (int i = 0; i < 6; i++) pkts[7].bytes[i] = 8'($random(seed));

        cycle_limit = 10 * 2 + 500;
        for (int e = 0; e < NUM_PKTS; e++) cycle_limit += pkt_cycles(pkts[e]);

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drive_line(usb_rx_pkg::J, 2);
        check("empty", empty, 1'b1);
        check("full", full, 1'b0);
        check("status.receiving", status.receiving, 1'b0);
        check("status.rx_error", status.rx_error, 1'b0);

        for (int e = 0; e < NUM_PKTS; e++) begin
            send_packet(pkts[e]);
            model_packet(pkts[e]);
            check("status.rx_error", status.rx_error, pkts[e].exp_error);
            check("status.receiving", status.receiving, 1'b0);
            check("full", full, model.size() == FIFO_DEPTH);
            check("empty", empty, model.size() == 0);
            check("status.data_ready", status.data_ready, model.size() != 0);
            if (!pkts[e].hold) drain_fifo();
            $display("packet %0d done", e);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* usb_rx.f */
source/usb_rx_pkg.sv
source/flex_counter.sv
source/bit_timer.sv
source/line_decoder.sv
source/rx_control.sv
source/rx_fifo.sv
source/usb_rx.sv
dv/tb_clock.sv
dv/tb_usb_rx.sv

/* Bender.yml */
package:
  name: usb_rx

sources:
  - source/usb_rx_pkg.sv
  - source/flex_counter.sv
  - source/bit_timer.sv
  - source/line_decoder.sv
  - source/rx_control.sv
  - source/rx_fifo.sv
  - source/usb_rx.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_usb_rx.sv
